/* src.f */
+incdir+.
div_pkg.sv
div_start_if.sv
div_done_if.sv
div_special.sv
div_core.sv
div_result.sv
div_top.sv
tb_div.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_div
FILELIST  = src.f
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* tb_div.sv */
//////////////////////////////////////////////////////////////////////
// directed testbench for the RV32M divider
// expected values from truncating division, remainder follows dividend
// latency counts edges from the issuing edge through the result edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_div;

  localparam int clk_period = 40;
  localparam int num_tests  = 91;   // reset, 80 random, 6 special, 4 blocked
  localparam int max_wait   = 40;   // cycles allowed per result
  localparam logic [31:0] add_instr = {7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011};

  logic            clk;
  logic            rstn;
  logic            ex_stall;
  logic            id_bubble;
  logic [31:0]     id_instr;
  div_pkg::xlen_t  opa;
  div_pkg::xlen_t  opb;
  logic            div_stall;
  logic            div_bubble;
  div_pkg::xlen_t  div_r;

  integer seed;
  int     cyc     = 0;  // rising edges so far
  int     strobes = 0;  // div_bubble low cycles
  int     tests   = 0;
  int     checks  = 0;
  int     errors  = 0;

  div_top dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (rstn && !div_bubble)
      strobes <= strobes + 1;  // counted on the edge closing the strobe
  end

  initial
  begin
    #(num_tests * max_wait * 2 * clk_period);
    $display("watchdog expired, tests did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model

  // R-type word, rd x3, rs1 x1, rs2 x2
  function automatic logic [31:0] encode_div(input div_pkg::div_op_e op);
    logic [2:0] f3;
    case (op)
      div_pkg::OP_DIV:  f3 = 3'b100;
      div_pkg::OP_DIVU: f3 = 3'b101;
      div_pkg::OP_REM:  f3 = 3'b110;
      default:          f3 = 3'b111;
    endcase
    return {7'b0000001, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  function automatic logic is_special(input div_pkg::div_op_e op,
                                      input div_pkg::xlen_t a, input div_pkg::xlen_t b);
    logic sgn;
    sgn = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
    return (b == '0) || (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff);
  endfunction

  function automatic div_pkg::xlen_t expect_result(input div_pkg::div_op_e op,
                                                   input div_pkg::xlen_t a,
                                                   input div_pkg::xlen_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op)
      div_pkg::OP_DIVU: return (b == '0) ? '1 : a / b;
      div_pkg::OP_REMU: return (b == '0) ? a : a % b;
      div_pkg::OP_DIV:
        if (b == '0)
          return '1;
        else if (is_special(op, a, b))
          return 32'h8000_0000;  // overflow wraps
        else
          return sa / sb;        // truncates toward zero
      default:
        if (b == '0)
          return a;
        else if (is_special(op, a, b))
          return '0;
        else
          return sa % sb;        // sign of dividend
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic compare_word(input string name, input div_pkg::xlen_t exp,
                              input div_pkg::xlen_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_latency(input string name, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("FAILED %s latency: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0)
      $display("ok     %s", name);
    else
      $display("error  %s", name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and wait

  // returns at the negedge after the issuing edge
  task automatic issue(input logic [31:0] instr, input div_pkg::xlen_t a,
                       input div_pkg::xlen_t b, output int start);
    @(posedge clk);
    id_instr  <= instr;
    opa       <= a;
    opb       <= b;
    ex_stall  <= 1'b0;
    id_bubble <= 1'b0;
    @(posedge clk);          // issuing edge
    id_bubble <= 1'b1;
    @(negedge clk);
    start = cyc;
  endtask

  // polls at negedges, bounded by max_wait
  task automatic wait_strobe(input int start, output logic seen, output int lat);
    seen = 1'b0;
    lat  = 0;
    while (!seen && cyc - start < max_wait)
    begin
      if (!div_bubble)
      begin
        seen = 1'b1;
        lat  = cyc - start + 1;
      end
      else
        @(negedge clk);
    end
  endtask

  task automatic check_div(input string name, input div_pkg::div_op_e op,
                           input div_pkg::xlen_t a, input div_pkg::xlen_t b);
    div_pkg::xlen_t exp_val;
    int             exp_lat;
    int             start;
    int             lat;
    logic           seen;
    exp_val = expect_result(op, a, b);
    exp_lat = is_special(op, a, b) ? 1 : 34;  // special answered at issue
    issue(encode_div(op), a, b, start);
    compare_flag({name, " stall"}, exp_lat != 1, div_stall);
    wait_strobe(start, seen, lat);
    if (!seen)
    begin
      errors++;
      $display("%s: no result strobe within %0d cycles", name, max_wait);
    end
    else
    begin
      compare_word(name, exp_val, div_r);
      compare_latency(name, exp_lat, lat);
      @(negedge clk);
      compare_flag({name, " strobe width"}, 1'b1, div_bubble);  // one cycle only
    end
  endtask

  task automatic run_div(input string name, input div_pkg::div_op_e op,
                         input div_pkg::xlen_t a, input div_pkg::xlen_t b);
    int err0;
    err0 = errors;
    check_div(name, op, a, b);
    report_test(name, err0);
  endtask

  // blocked instruction held for a while, then a normal divide
  task automatic run_blocked(input string name, input logic [31:0] instr,
                             input logic stall, input logic bubble);
    int err0;
    int cnt0;
    err0 = errors;
    cnt0 = strobes;
    @(posedge clk);
    id_instr  <= instr;
    opa       <= 32'd1000;
    opb       <= '0;           // zero divisor, strobes at once if it issued
    ex_stall  <= stall;
    id_bubble <= bubble;
    repeat (8) @(posedge clk);
    ex_stall  <= 1'b0;
    id_bubble <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checks++;
    if (strobes != cnt0)
    begin
      errors++;
      $display("%s: result strobe appeared without an issue", name);
    end
    check_div(name, div_pkg::OP_DIV, 32'd1000, 32'd7);
    report_test(name, err0);
  endtask

  // second divide presented while the loop is busy
  task automatic run_busy(input string name);
    int   err0;
    int   cnt0;
    int   start;
    int   lat;
    logic seen;
    err0 = errors;
    cnt0 = strobes;
    issue(encode_div(div_pkg::OP_DIVU), 32'hdead_beef, 32'd13, start);
    @(posedge clk);
    id_instr  <= encode_div(div_pkg::OP_REM);  // zero divisor, special if it issued
    opa       <= 32'h1234_5678;
    opb       <= '0;
    id_bubble <= 1'b0;
    repeat (20) @(posedge clk);
    id_bubble <= 1'b1;                         // gone before the loop frees up
    @(negedge clk);
    wait_strobe(start, seen, lat);
    if (!seen)
    begin
      errors++;
      $display("%s: no result strobe within %0d cycles", name, max_wait);
    end
    else
    begin
      compare_word(name, expect_result(div_pkg::OP_DIVU, 32'hdead_beef, 32'd13), div_r);
      compare_latency(name, 34, lat);          // first divide runs undisturbed
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    checks++;
    if (strobes != cnt0 + 1)
    begin
      errors++;
      $display("%s: %0d result strobes seen where one was expected", name, strobes - cnt0);
    end
    report_test(name, err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    div_pkg::xlen_t a;
    div_pkg::xlen_t b;
    div_pkg::xlen_t ma;
    div_pkg::xlen_t mb;
    int             sh;
    int             err0;
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    id_bubble = 1'b1;
    id_instr  = '0;
    opa       = '0;
    opb       = '0;
    seed      = 30168;
    repeat (2) @(posedge clk);
    @(negedge clk);
    err0 = errors;
    compare_flag("reset bubble", 1'b1, div_bubble);
    compare_flag("reset stall", 1'b0, div_stall);
    report_test("reset", err0);
    @(posedge clk);                  // third reset edge
    rstn <= 1'b1;

    // unsigned, divisor scaled down for varied quotients
    for (int i = 0; i < 20; i++)
    begin
      a  = $random(seed);
      sh = $random(seed) & 31;
      b  = div_pkg::xlen_t'($random(seed)) >> sh;
      if (b == '0)
        b = 32'd1;
      run_div($sformatf("divu_%0d", i), div_pkg::OP_DIVU, a, b);
      run_div($sformatf("remu_%0d", i), div_pkg::OP_REMU, a, b);
    end

    // signed, i[1:0] picks the sign pair
    for (int i = 0; i < 20; i++)
    begin
      ma = div_pkg::xlen_t'($random(seed)) & 32'h7fff_ffff;
      sh = $random(seed) & 31;
      mb = (div_pkg::xlen_t'($random(seed)) & 32'h7fff_ffff) >> sh;
      if (mb == '0)
        mb = 32'd1;
      a = i[0] ? -ma : ma;
      b = i[1] ? -mb : mb;
      run_div($sformatf("div_%0d", i), div_pkg::OP_DIV, a, b);
      run_div($sformatf("rem_%0d", i), div_pkg::OP_REM, a, b);
    end

    // divide by zero, then overflow
    a = $random(seed);
    run_div("div_zero", div_pkg::OP_DIV, a, '0);
    run_div("divu_zero", div_pkg::OP_DIVU, a, '0);
    run_div("rem_zero", div_pkg::OP_REM, a, '0);
    run_div("remu_zero", div_pkg::OP_REMU, a, '0);
    run_div("div_ovf", div_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_div("rem_ovf", div_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff);

    // issue gating
    run_blocked("blk_ex_stall", encode_div(div_pkg::OP_DIV), 1'b1, 1'b0);
    run_blocked("blk_id_bubble", encode_div(div_pkg::OP_DIV), 1'b0, 1'b1);
    run_blocked("blk_not_div", add_instr, 1'b0, 1'b0);
    run_busy("blk_busy");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* div_top.sv */
//////////////////////////////////////////////////////////////////////
// RV32M divider, top level
// strobes and levels only, no handshake on the result
// ex_stall and id_bubble only block a new issue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module div_top
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic            id_bubble,
  input  logic [31:0]     id_instr,
  input  div_pkg::xlen_t  opa,
  input  div_pkg::xlen_t  opb,
  output logic            div_stall,
  output logic            div_bubble,
  output div_pkg::xlen_t  div_r
);

  logic            special_valid;  // issue answered without the loop
  div_pkg::xlen_t  special_value;
  logic            busy;           // loop occupied

  div_start_if start_bus ();
  div_done_if  done_bus ();

  div_special u_special
  (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .id_instr      (id_instr),
    .opa           (opa),
    .opb           (opb),
    .busy          (busy),
    .special_valid (special_valid),
    .special_value (special_value),
    .req           (start_bus.special)
  );

  div_core u_core
  (
    .clk       (clk),
    .rstn      (rstn),
    .busy      (busy),
    .div_stall (div_stall),
    .req       (start_bus.core),
    .res       (done_bus.core)
  );

  div_result u_result
  (
    .clk           (clk),
    .rstn          (rstn),
    .special_valid (special_valid),
    .special_value (special_value),
    .div_bubble    (div_bubble),
    .div_r         (div_r),
    .res           (done_bus.result)
  );

endmodule

/* div_result.sv */
//////////////////////////////////////////////////////////////////////
// sign correction and result register
// div_bubble low for exactly one cycle per result, never held
// div_r keeps its value until the next result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module div_result
(
  input  logic            clk,
  input  logic            rstn,
  input  logic            special_valid,
  input  div_pkg::xlen_t  special_value,
  output logic            div_bubble,
  output div_pkg::xlen_t  div_r,
  div_done_if.result      res
);

  div_pkg::xlen_t  quo_s;     // signed quotient
  div_pkg::xlen_t  rem_s;     // signed remainder
  div_pkg::xlen_t  iter_val;  // loop answer after correction

  //////////////////////////////////////////////////////////////////////
  // sign correction

  // truncating division, negate magnitudes where needed
  assign quo_s = res.neg_q ? -res.quotient  : res.quotient;
  assign rem_s = res.neg_r ? -res.remainder : res.remainder;

  assign iter_val = res.is_rem ? rem_s : quo_s;

  //////////////////////////////////////////////////////////////////////
  // output registers

  // strobe, active low
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      div_bubble <= 1'b1;
    else
      div_bubble <= !(res.done || special_valid);
  end

  always_ff @(posedge clk)
  begin
    if (special_valid)
      div_r <= special_value;   // answered at issue
    else if (res.done)
      div_r <= iter_val;
  end

  // a special issue cannot land on the loop's last edge
  a_no_collide: assert property (@(posedge clk) disable iff (!rstn)
    !(res.done && special_valid));

endmodule

/* div_core.sv */
//////////////////////////////////////////////////////////////////////
// bit-serial restoring divide loop
// 32 steps in ST_DIV, one in ST_RES, one division in flight at a time
// works on magnitudes, sign flags travel alongside to the output stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "div_config.svh"

module div_core
(
  input  logic   clk,
  input  logic   rstn,
  output logic   busy,
  output logic   div_stall,
  div_start_if.core  req,
  div_done_if.core   res
);

  div_pkg::div_state_e    state;
  logic [`DIV_CNT_W-1:0]  cnt;        // steps left minus one
  div_pkg::div_op_e       op_q;       // op held for the result stage
  logic                   neg_q;
  logic                   neg_r;
  div_pkg::xlen_t         part_rem;   // partial remainder
  div_pkg::xlen_t         dvd_q;      // dividend bits out, quotient bits in
  div_pkg::xlen_t         dvsr;       // |divisor|
  logic                   is_signed;
  div_pkg::xlen_t         abs_dvd;
  div_pkg::xlen_t         abs_dvs;
  logic [`DIV_XLEN:0]     rem_sh;     // remainder after the left shift
  logic [`DIV_XLEN+1:0]   diff;       // trial subtract, msb is borrow

  //////////////////////////////////////////////////////////////////////
  // operand prep

  assign is_signed = (req.op == div_pkg::OP_DIV) || (req.op == div_pkg::OP_REM);

  // unsigned ops pass through untouched
  assign abs_dvd = (is_signed && req.dividend[`DIV_XLEN-1]) ? -req.dividend : req.dividend;
  assign abs_dvs = (is_signed && req.divisor[`DIV_XLEN-1])  ? -req.divisor  : req.divisor;

  //////////////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state     <= div_pkg::ST_IDLE;
      cnt       <= '0;
      div_stall <= 1'b0;
    end
    else
    begin
      case (state)
        div_pkg::ST_IDLE:
          if (req.start)
          begin
            state     <= div_pkg::ST_DIV;
            cnt       <= '1;  // 31 down to 0
            div_stall <= 1'b1;
          end
        div_pkg::ST_DIV:
        begin
          cnt <= cnt - 1'b1;
          if (cnt == '0)
            state <= div_pkg::ST_RES;  // last step taken
        end
        div_pkg::ST_RES:
        begin
          state     <= div_pkg::ST_IDLE;
          div_stall <= 1'b0;           // released with the result edge
        end
        default: state <= div_pkg::ST_IDLE;
      endcase
    end
  end

  assign busy = (state != div_pkg::ST_IDLE);

  //////////////////////////////////////////////////////////////////////
  // restoring datapath

  // extra top bit, an unsigned divisor above 2^31 can push the shift past 32 bits
  assign rem_sh = {part_rem, dvd_q[`DIV_XLEN-1]};
  assign diff   = {1'b0, rem_sh} - {2'b00, dvsr};

  always_ff @(posedge clk)
  begin
    if (state == div_pkg::ST_IDLE && req.start)
    begin
      op_q     <= req.op;
      neg_q    <= is_signed && (req.dividend[`DIV_XLEN-1] ^ req.divisor[`DIV_XLEN-1]);
      neg_r    <= is_signed && req.dividend[`DIV_XLEN-1];  // follows dividend
      part_rem <= '0;
      dvd_q    <= abs_dvd;
      dvsr     <= abs_dvs;
    end
    else if (state == div_pkg::ST_DIV)
    begin
      if (diff[`DIV_XLEN+1])
      begin
        part_rem <= rem_sh[`DIV_XLEN-1:0];            // borrow, restore
        dvd_q    <= {dvd_q[`DIV_XLEN-2:0], 1'b0};
      end
      else
      begin
        part_rem <= diff[`DIV_XLEN-1:0];              // keep the difference
        dvd_q    <= {dvd_q[`DIV_XLEN-2:0], 1'b1};
      end
    end
  end

  // handover, combinational while in ST_RES
  assign res.done      = (state == div_pkg::ST_RES);
  assign res.quotient  = dvd_q;
  assign res.remainder = part_rem;
  assign res.neg_q     = neg_q;
  assign res.neg_r     = neg_r;
  assign res.is_rem    = (op_q == div_pkg::OP_REM) || (op_q == div_pkg::OP_REMU);

  // issue side must see busy and hold off
  a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    req.start |-> state == div_pkg::ST_IDLE);

  a_stall_state: assert property (@(posedge clk) disable iff (!rstn)
    div_stall == (state != div_pkg::ST_IDLE));

endmodule

/* div_special.sv */
//////////////////////////////////////////////////////////////////////
// decode and issue for the divider
// issue needs ex_stall, id_bubble and busy all low
// divide by zero and signed overflow are answered here, never looped
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "div_config.svh"

module div_special
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              ex_stall,
  input  logic              id_bubble,
  input  logic [31:0]       id_instr,
  input  div_pkg::xlen_t    opa,
  input  div_pkg::xlen_t    opb,
  input  logic              busy,
  output logic              special_valid,
  output div_pkg::xlen_t    special_value,
  div_start_if.special      req
);

  localparam div_pkg::xlen_t most_neg = {1'b1, {(`DIV_XLEN-1){1'b0}}};

  logic [6:0]        funct7;
  logic [2:0]        funct3;
  logic [4:0]        opcode;
  div_pkg::div_op_e  op;
  logic              issue;
  logic              op_signed;
  logic              op_rem;
  logic              div_zero;
  logic              overflow;

  //////////////////////////////////////////////////////////////////////
  // instruction decode

  assign funct7 = id_instr[31:25];
  assign funct3 = id_instr[14:12];
  assign opcode = id_instr[6:2];

  always_comb
  begin
    op = div_pkg::OP_NONE;
    // 32 bit encodings only, low bits 11
    if (funct7 == `DIV_FUNCT7_MULDIV && opcode == `DIV_OPCODE_OP && id_instr[1:0] == 2'b11)
    begin
      case (funct3)
        `DIV_F3_DIV:  op = div_pkg::OP_DIV;
        `DIV_F3_DIVU: op = div_pkg::OP_DIVU;
        `DIV_F3_REM:  op = div_pkg::OP_REM;
        `DIV_F3_REMU: op = div_pkg::OP_REMU;
        default:      op = div_pkg::OP_NONE;  // mul forms
      endcase
    end
  end

  assign op_signed = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
  assign op_rem    = (op == div_pkg::OP_REM) || (op == div_pkg::OP_REMU);

  // single issue point of the whole divider
  assign issue = !ex_stall && !id_bubble && !busy && (op != div_pkg::OP_NONE);

  //////////////////////////////////////////////////////////////////////
  // special cases

  assign div_zero = (opb == '0);
  assign overflow = op_signed && (opa == most_neg) && (opb == '1);  // -2^31 / -1

  always_comb
  begin
    if (div_zero)
      special_value = op_rem ? opa : '1;     // rem keeps dividend, div all ones
    else
      special_value = op_rem ? '0 : opa;     // overflow, quotient wraps to -2^31
  end

  assign special_valid = issue && (div_zero || overflow);

  // everything else goes through the loop
  assign req.start    = issue && !(div_zero || overflow);
  assign req.op       = op;
  assign req.dividend = opa;
  assign req.divisor  = opb;

  // busy must follow every start into the loop
  a_start_taken: assert property (@(posedge clk) disable iff (!rstn)
    req.start |=> busy);

endmodule

/* div_done_if.sv */
//////////////////////////////////////////////////////////////////////
// raw loop result towards sign correction
// quotient and remainder are unsigned magnitudes
// all fields only hold meaning while done is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface div_done_if;

  logic            done;       // one cycle, loop finished
  div_pkg::xlen_t  quotient;   // |dividend| / |divisor|
  div_pkg::xlen_t  remainder;  // |dividend| % |divisor|
  logic            neg_q;      // quotient must be negated
  logic            neg_r;      // remainder must be negated
  logic            is_rem;     // REM/REMU, else DIV/DIVU

  // loop side
  modport core
  (
    output done,
    output quotient,
    output remainder,
    output neg_q,
    output neg_r,
    output is_rem
  );

  // output stage
  modport result
  (
    input  done,
    input  quotient,
    input  remainder,
    input  neg_q,
    input  neg_r,
    input  is_rem
  );

endinterface

/* div_start_if.sv */
//////////////////////////////////////////////////////////////////////
// start request into the iterative loop
// start is a single-cycle pulse, the other fields are valid with it
// operands are the raw register values, signs not yet removed
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface div_start_if;

  logic              start;     // issue of a non-special divide
  div_pkg::div_op_e  op;        // decoded operation
  div_pkg::xlen_t    dividend;  // opa as presented at issue
  div_pkg::xlen_t    divisor;   // opb, never zero when start is high

  // issue side
  modport special
  (
    output start,
    output op,
    output dividend,
    output divisor
  );

  // loop side
  modport core
  (
    input  start,
    input  op,
    input  dividend,
    input  divisor
  );

endinterface

/* div_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types of the divider
// op codes only cover the four RV32M divide forms
// word forms of RV64 decode to OP_NONE
//////////////////////////////////////////////////////////////////////

`include "div_config.svh"

package div_pkg;

  //////////////////////////////////////////////////////////////////////
  // data

  typedef logic [`DIV_XLEN-1:0] xlen_t;  // one register word

  //////////////////////////////////////////////////////////////////////
  // decoded operation

  typedef enum logic [2:0]
  {
    OP_NONE = 3'd0,  // not a divide, never issued
    OP_DIV  = 3'd1,  // signed quotient
    OP_DIVU = 3'd2,  // unsigned quotient
    OP_REM  = 3'd3,  // signed remainder
    OP_REMU = 3'd4   // unsigned remainder
  } div_op_e;

  //////////////////////////////////////////////////////////////////////
  // iterative loop control

  typedef enum logic [1:0]
  {
    ST_IDLE = 2'd0,  // waiting for start
    ST_DIV  = 2'd1,  // shift-subtract steps
    ST_RES  = 2'd2   // raw result handed over
  } div_state_e;

endpackage

/* div_config.svh */
//////////////////////////////////////////////////////////////////////
// width and decode constants for the RV32M divider
// only DIV_XLEN of 32 is supported, DIV_CNT_W must be log2 of it
// field codes follow the base RISC-V encoding of the M extension
//////////////////////////////////////////////////////////////////////

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// data path
`define DIV_XLEN           32        // one data word
`define DIV_CNT_W          5         // loop step counter

// instruction fields
`define DIV_OPCODE_OP      5'b01100  // opcode[6:2] of reg-reg ALU ops
`define DIV_FUNCT7_MULDIV  7'b0000001

// funct3 codes of the four divide forms
`define DIV_F3_DIV         3'b100
`define DIV_F3_DIVU        3'b101
`define DIV_F3_REM         3'b110
`define DIV_F3_REMU        3'b111

`endif
